// ==== design/z80_seq_pkg.sv ====
package z80_seq_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;

    // singles follow the z80 three-bit order, pairs sit above them
    typedef enum logic [3:0] {
        reg_b   = 4'd0,
        reg_c   = 4'd1,
        reg_d   = 4'd2,
        reg_e   = 4'd3,
        reg_h   = 4'd4,
        reg_l   = 4'd5,
        reg_mem = 4'd6, // (HL) slot, not a register
        reg_a   = 4'd7,
        reg_bc  = 4'd8,
        reg_de  = 4'd9,
        reg_hl  = 4'd10,
        reg_sp  = 4'd11
    } reg_sel_t;

    typedef enum logic [3:0] {
        grp_nop,
        grp_ld_r_r,
        grp_ld_r_n,
        grp_ld_hl_n,
        grp_ld_hl_r,
        grp_ld_bcde_a,
        grp_ld_a_bcde,
        grp_ld_dd_nn,
        grp_ld_a_nn,
        grp_ld_nn_a
    } insn_group_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_s1,
        st_s2,
        st_s3
    } seq_state_t;

    typedef enum logic [1:0] {
        opnd_keep,
        opnd_load_lo,
        opnd_load_hi,
        opnd_save_return
    } opnd_ctl_t;

    typedef struct packed {
        insn_group_t group;
        logic [2:0]  dst;    // opcode bits 5:3
        logic [2:0]  src;    // opcode bits 2:0
        logic [1:0]  pair;   // opcode bits 5:4
        logic        de_sel; // opcode bit 4
    } decoded_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              rd;
        logic              wr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        en;
        reg_sel_t    sel;
        logic [15:0] data; // low byte only for single registers
    } reg_wr_t;

endpackage

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  z80_seq_pkg::reg_wr_t  i_wr,
    input  z80_seq_pkg::reg_sel_t i_rd_sel1,
    input  z80_seq_pkg::reg_sel_t i_rd_sel2,
    output logic [15:0]          o_rd_data1,
    output logic [15:0]          o_rd_data2
);

    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  d;
    logic [7:0]  e;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [7:0]  a;
    logic [15:0] sp;

    function automatic logic [15:0] read_sel(input z80_seq_pkg::reg_sel_t sel);
        case (sel)
            z80_seq_pkg::reg_b:  return {8'h00, b};
            z80_seq_pkg::reg_c:  return {8'h00, c};
            z80_seq_pkg::reg_d:  return {8'h00, d};
            z80_seq_pkg::reg_e:  return {8'h00, e};
            z80_seq_pkg::reg_h:  return {8'h00, h};
            z80_seq_pkg::reg_l:  return {8'h00, l};
            z80_seq_pkg::reg_a:  return {8'h00, a};
            z80_seq_pkg::reg_bc: return {b, c};
            z80_seq_pkg::reg_de: return {d, e};
            z80_seq_pkg::reg_hl: return {h, l};
            z80_seq_pkg::reg_sp: return sp;
            default:             return 16'h0000;
        endcase
    endfunction

    always_comb begin
        o_rd_data1 = read_sel(i_rd_sel1);
        o_rd_data2 = read_sel(i_rd_sel2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {b, c, d, e, h, l, a} <= '0;
            sp <= '0;
        end else if (i_wr.en) begin
            case (i_wr.sel)
                z80_seq_pkg::reg_b:  b <= i_wr.data[7:0];
                z80_seq_pkg::reg_c:  c <= i_wr.data[7:0];
                z80_seq_pkg::reg_d:  d <= i_wr.data[7:0];
                z80_seq_pkg::reg_e:  e <= i_wr.data[7:0];
                z80_seq_pkg::reg_h:  h <= i_wr.data[7:0];
                z80_seq_pkg::reg_l:  l <= i_wr.data[7:0];
                z80_seq_pkg::reg_a:  a <= i_wr.data[7:0];
                z80_seq_pkg::reg_bc: {b, c} <= i_wr.data; // high byte to b
                z80_seq_pkg::reg_de: {d, e} <= i_wr.data;
                z80_seq_pkg::reg_hl: {h, l} <= i_wr.data;
                z80_seq_pkg::reg_sp: sp <= i_wr.data;
                default: ;
            endcase
        end
    end

endmodule

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            i_opcode,
    input  logic                  i_capture,
    output z80_seq_pkg::decoded_t o_dec
);

    z80_seq_pkg::decoded_t fresh;
    z80_seq_pkg::decoded_t held;

    function automatic z80_seq_pkg::decoded_t decode(input logic [7:0] op);
        z80_seq_pkg::decoded_t dec;
        dec.dst    = op[5:3];
        dec.src    = op[2:0];
        dec.pair   = op[5:4];
        dec.de_sel = op[4];
        dec.group  = z80_seq_pkg::grp_nop;
        if (op[7:6] == 2'b01) begin
            // 0x76 halt and LD r,(HL) fall through as nop
            if (op[5:3] == 3'b110 && op[2:0] != 3'b110)
                dec.group = z80_seq_pkg::grp_ld_hl_r;
            else if (op[5:3] != 3'b110 && op[2:0] != 3'b110)
                dec.group = z80_seq_pkg::grp_ld_r_r;
        end else if (op[7:6] == 2'b00) begin
            if (op[2:0] == 3'b110) begin
                dec.group = (op[5:3] == 3'b110) ? z80_seq_pkg::grp_ld_hl_n
                                                : z80_seq_pkg::grp_ld_r_n;
            end else if (op[3:0] == 4'b0001) begin
                dec.group = z80_seq_pkg::grp_ld_dd_nn;
            end else begin
                case (op)
                    8'h02, 8'h12: dec.group = z80_seq_pkg::grp_ld_bcde_a;
                    8'h0a, 8'h1a: dec.group = z80_seq_pkg::grp_ld_a_bcde;
                    8'h32:        dec.group = z80_seq_pkg::grp_ld_nn_a;
                    8'h3a:        dec.group = z80_seq_pkg::grp_ld_a_nn;
                    default: ;
                endcase
            end
        end
        return dec;
    endfunction

    assign fresh = decode(i_opcode);
    assign o_dec = i_capture ? fresh : held; // live during fetch only

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            held <= '0;
        else if (i_capture)
            held <= fresh;
    end

endmodule

// ==== design/operand_collector.sv ====
`timescale 1ns/1ps

module operand_collector (
    input  logic                   clk,
    input  logic                   reset,
    input  z80_seq_pkg::opnd_ctl_t i_ctl,
    input  logic [15:0]            i_val,
    output logic [15:0]            o_scratch_addr,
    output logic [15:0]            o_scratch_data
);

    logic [15:0] scratch_addr;
    logic [15:0] scratch_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scratch_addr <= '0;
            scratch_data <= '0;
        end else begin
            case (i_ctl)
                z80_seq_pkg::opnd_load_lo:     scratch_data <= {8'h00, i_val[7:0]};
                z80_seq_pkg::opnd_load_hi:     scratch_data[15:8] <= i_val[7:0];
                z80_seq_pkg::opnd_save_return: scratch_addr <= i_val; // pc after insn
                default: ;
            endcase
        end
    end

    assign o_scratch_addr = scratch_addr;
    assign o_scratch_data = scratch_data;

endmodule

// ==== design/load_sequencer.sv ====
`timescale 1ns/1ps

module load_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             i_mem_data,
    input  z80_seq_pkg::decoded_t  i_dec,
    input  logic [15:0]            i_rd_data1,
    input  logic [15:0]            i_rd_data2,
    input  logic [15:0]            i_scratch_addr,
    input  logic [15:0]            i_scratch_data,
    output z80_seq_pkg::mem_req_t  o_mem,
    output logic                   o_done,
    output z80_seq_pkg::reg_sel_t  o_rd_sel1,
    output z80_seq_pkg::reg_sel_t  o_rd_sel2,
    output z80_seq_pkg::reg_wr_t   o_reg_wr,
    output logic                   o_capture,
    output z80_seq_pkg::opnd_ctl_t o_opnd_ctl,
    output logic [15:0]            o_opnd_val
);

    z80_seq_pkg::seq_state_t state;
    z80_seq_pkg::seq_state_t next_state;
    z80_seq_pkg::mem_req_t   next_mem;
    logic                    next_done;
    logic                    finish;
    logic [15:0]             fin_addr;
    logic [15:0]             pc;
    logic [15:0]             nn;
    z80_seq_pkg::reg_sel_t   dst_sel;
    z80_seq_pkg::reg_sel_t   src_sel;
    z80_seq_pkg::reg_sel_t   pair_sel;
    z80_seq_pkg::reg_sel_t   ind_sel;

    assign pc        = o_mem.addr;
    assign nn        = {i_mem_data, i_scratch_data[7:0]}; // high byte arrives last
    assign dst_sel   = z80_seq_pkg::reg_sel_t'({1'b0, i_dec.dst});
    assign src_sel   = z80_seq_pkg::reg_sel_t'({1'b0, i_dec.src});
    assign pair_sel  = z80_seq_pkg::reg_sel_t'({2'b10, i_dec.pair});
    assign ind_sel   = i_dec.de_sel ? z80_seq_pkg::reg_de : z80_seq_pkg::reg_bc;
    assign o_capture = (state == z80_seq_pkg::st_fetch);

    always_comb begin
        next_state    = z80_seq_pkg::st_fetch;
        next_mem      = '0;
        next_mem.addr = pc;
        finish        = 1'b0;
        fin_addr      = pc + 16'd1;
        o_rd_sel1     = z80_seq_pkg::reg_hl;
        o_rd_sel2     = src_sel;
        o_reg_wr      = '0;
        o_opnd_ctl    = z80_seq_pkg::opnd_keep;
        o_opnd_val    = {8'h00, i_mem_data};

        case (state)
            z80_seq_pkg::st_fetch: begin
                case (i_dec.group)
                    z80_seq_pkg::grp_ld_r_r: begin
                        o_rd_sel1 = src_sel;
                        o_reg_wr  = '{en: 1'b1, sel: dst_sel, data: i_rd_data1};
                        finish    = 1'b1;
                    end
                    z80_seq_pkg::grp_ld_r_n, z80_seq_pkg::grp_ld_dd_nn: begin
                        next_mem.rd   = 1'b1; // operand byte
                        next_mem.addr = pc + 16'd1;
                        next_state    = z80_seq_pkg::st_s1;
                    end
                    z80_seq_pkg::grp_ld_hl_n, z80_seq_pkg::grp_ld_a_nn,
                    z80_seq_pkg::grp_ld_nn_a: begin
                        next_mem.rd   = 1'b1;
                        next_mem.addr = pc + 16'd1;
                        o_opnd_ctl    = z80_seq_pkg::opnd_save_return;
                        o_opnd_val    = (i_dec.group == z80_seq_pkg::grp_ld_hl_n) ?
                                        pc + 16'd2 : pc + 16'd3;
                        next_state    = z80_seq_pkg::st_s1;
                    end
                    z80_seq_pkg::grp_ld_hl_r: begin
                        next_mem.wr    = 1'b1;
                        next_mem.addr  = i_rd_data1;
                        next_mem.wdata = i_rd_data2[7:0];
                        o_opnd_ctl     = z80_seq_pkg::opnd_save_return;
                        o_opnd_val     = pc + 16'd1;
                        next_state     = z80_seq_pkg::st_s1;
                    end
                    z80_seq_pkg::grp_ld_bcde_a, z80_seq_pkg::grp_ld_a_bcde: begin
                        o_rd_sel1      = ind_sel;
                        o_rd_sel2      = z80_seq_pkg::reg_a;
                        next_mem.addr  = i_rd_data1;
                        next_mem.wr    = (i_dec.group == z80_seq_pkg::grp_ld_bcde_a);
                        next_mem.rd    = (i_dec.group == z80_seq_pkg::grp_ld_a_bcde);
                        next_mem.wdata = next_mem.wr ? i_rd_data2[7:0] : 8'h00;
                        o_opnd_ctl     = z80_seq_pkg::opnd_save_return;
                        o_opnd_val     = pc + 16'd1;
                        next_state     = z80_seq_pkg::st_s1;
                    end
                    default: finish = 1'b1; // nop, pc + 1
                endcase
            end

            z80_seq_pkg::st_s1: begin
                case (i_dec.group)
                    z80_seq_pkg::grp_ld_r_n: begin
                        o_reg_wr = '{en: 1'b1, sel: dst_sel, data: {8'h00, i_mem_data}};
                        finish   = 1'b1;
                    end
                    z80_seq_pkg::grp_ld_hl_n: begin
                        next_mem.wr    = 1'b1;
                        next_mem.addr  = i_rd_data1;
                        next_mem.wdata = i_mem_data;
                        next_state     = z80_seq_pkg::st_s2;
                    end
                    z80_seq_pkg::grp_ld_dd_nn, z80_seq_pkg::grp_ld_a_nn,
                    z80_seq_pkg::grp_ld_nn_a: begin
                        o_opnd_ctl    = z80_seq_pkg::opnd_load_lo;
                        next_mem.rd   = 1'b1;
                        next_mem.addr = pc + 16'd1;
                        next_state    = z80_seq_pkg::st_s2;
                    end
                    default: begin
                        if (i_dec.group == z80_seq_pkg::grp_ld_a_bcde)
                            o_reg_wr = '{en: 1'b1, sel: z80_seq_pkg::reg_a,
                                         data: {8'h00, i_mem_data}};
                        finish   = 1'b1;
                        fin_addr = i_scratch_addr;
                    end
                endcase
            end

            z80_seq_pkg::st_s2: begin
                case (i_dec.group)
                    z80_seq_pkg::grp_ld_dd_nn: begin
                        o_reg_wr = '{en: 1'b1, sel: pair_sel, data: nn};
                        finish   = 1'b1;
                    end
                    z80_seq_pkg::grp_ld_a_nn, z80_seq_pkg::grp_ld_nn_a: begin
                        o_opnd_ctl     = z80_seq_pkg::opnd_load_hi;
                        o_rd_sel1      = z80_seq_pkg::reg_a;
                        next_mem.addr  = nn;
                        next_mem.rd    = (i_dec.group == z80_seq_pkg::grp_ld_a_nn);
                        next_mem.wr    = (i_dec.group == z80_seq_pkg::grp_ld_nn_a);
                        next_mem.wdata = next_mem.wr ? i_rd_data1[7:0] : 8'h00;
                        next_state     = z80_seq_pkg::st_s3;
                    end
                    default: begin
                        finish   = 1'b1;
                        fin_addr = i_scratch_addr;
                    end
                endcase
            end

            default: begin
                if (i_dec.group == z80_seq_pkg::grp_ld_a_nn)
                    o_reg_wr = '{en: 1'b1, sel: z80_seq_pkg::reg_a, data: {8'h00, i_mem_data}};
                finish   = 1'b1;
                fin_addr = i_scratch_addr;
            end
        endcase

        // back to fetch at the return address
        next_done = finish;
        if (finish) begin
            next_mem.rd   = 1'b1;
            next_mem.addr = fin_addr;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= z80_seq_pkg::st_fetch;
            o_done <= 1'b1;
            o_mem  <= '{addr: '0, rd: 1'b1, wr: 1'b0, wdata: '0};
        end else begin
            state  <= next_state;
            o_done <= next_done;
            o_mem  <= next_mem;
        end
    end

endmodule

// ==== design/z80_load_core.sv ====
`timescale 1ns/1ps

module z80_load_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [z80_seq_pkg::data_w-1:0] i_mem_data,
    output logic [z80_seq_pkg::addr_w-1:0] o_addr,
    output logic                            o_read_mem,
    output logic                            o_write_mem,
    output logic [z80_seq_pkg::data_w-1:0] o_write_data,
    output logic                            o_done
);

    z80_seq_pkg::mem_req_t  mem;
    z80_seq_pkg::decoded_t  dec;
    z80_seq_pkg::reg_sel_t  rd_sel1;
    z80_seq_pkg::reg_sel_t  rd_sel2;
    z80_seq_pkg::reg_wr_t   reg_wr;
    z80_seq_pkg::opnd_ctl_t opnd_ctl;
    logic [15:0]            rd_data1;
    logic [15:0]            rd_data2;
    logic [15:0]            opnd_val;
    logic [15:0]            scratch_addr;
    logic [15:0]            scratch_data;
    logic                   capture;

    load_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .i_mem_data     (i_mem_data),
        .i_dec          (dec),
        .i_rd_data1     (rd_data1),
        .i_rd_data2     (rd_data2),
        .i_scratch_addr (scratch_addr),
        .i_scratch_data (scratch_data),
        .o_mem          (mem),
        .o_done         (o_done),
        .o_rd_sel1      (rd_sel1),
        .o_rd_sel2      (rd_sel2),
        .o_reg_wr       (reg_wr),
        .o_capture      (capture),
        .o_opnd_ctl     (opnd_ctl),
        .o_opnd_val     (opnd_val)
    );

    register_file u_regs (
        .clk        (clk),
        .reset      (reset),
        .i_wr       (reg_wr),
        .i_rd_sel1  (rd_sel1),
        .i_rd_sel2  (rd_sel2),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2)
    );

    instr_decoder u_dec (
        .clk       (clk),
        .reset     (reset),
        .i_opcode  (i_mem_data),
        .i_capture (capture),
        .o_dec     (dec)
    );

    operand_collector u_opnd (
        .clk            (clk),
        .reset          (reset),
        .i_ctl          (opnd_ctl),
        .i_val          (opnd_val),
        .o_scratch_addr (scratch_addr),
        .o_scratch_data (scratch_data)
    );

    assign o_addr       = mem.addr;
    assign o_read_mem   = mem.rd;
    assign o_write_mem  = mem.wr;
    assign o_write_data = mem.wdata;

endmodule

// ==== include/z80_ref_model.svh ====
`ifndef Z80_REF_MODEL_SVH
`define Z80_REF_MODEL_SVH

typedef struct packed {
    logic [15:0] pc;      // pc after the instruction
    logic [2:0]  cycles;  // done to done
    logic        wr_en;
    logic [15:0] wr_addr;
    logic [7:0]  wr_data;
} ref_step_t;

logic [7:0]  ref_mem [0:65535];
logic [7:0]  ref_regs [0:7]; // b c d e h l - a
logic [15:0] ref_sp;
logic [15:0] ref_pc;

function automatic void ref_reset();
    for (int i = 0; i < 8; i++)
        ref_regs[i] = 8'h00;
    ref_sp = 16'h0000;
    ref_pc = 16'h0000;
endfunction

// executes one instruction at ref_pc, memory write included
function automatic ref_step_t ref_step();
    ref_step_t   r;
    logic [7:0]  op;
    logic [7:0]  n1;
    logic [7:0]  n2;
    logic [15:0] hl;
    logic [15:0] ind;
    logic [1:0]  len;
    op  = ref_mem[ref_pc];
    n1  = ref_mem[ref_pc + 16'd1];
    n2  = ref_mem[ref_pc + 16'd2];
    hl  = {ref_regs[4], ref_regs[5]};
    ind = op[4] ? {ref_regs[2], ref_regs[3]} : {ref_regs[0], ref_regs[1]};
    r   = '0;
    len = 2'd1;
    r.cycles = 3'd1;
    if (op[7:6] == 2'b01 && op != 8'h76) begin
        if (op[5:3] == 3'b110) begin
            r = '{pc: '0, cycles: 3'd2, wr_en: 1'b1, wr_addr: hl, wr_data: ref_regs[op[2:0]]};
        end else if (op[2:0] != 3'b110) begin
            ref_regs[op[5:3]] = ref_regs[op[2:0]];
        end
    end else begin
        case (op)
            8'h02, 8'h12: r = '{pc: '0, cycles: 3'd2, wr_en: 1'b1, wr_addr: ind,
                                wr_data: ref_regs[7]};
            8'h0a, 8'h1a: begin
                r.cycles    = 3'd2;
                ref_regs[7] = ref_mem[ind];
            end
            8'h36: begin
                len = 2'd2;
                r   = '{pc: '0, cycles: 3'd3, wr_en: 1'b1, wr_addr: hl, wr_data: n1};
            end
            8'h01, 8'h11, 8'h21, 8'h31: begin
                len      = 2'd3;
                r.cycles = 3'd3;
                if (op[5:4] == 2'b11) begin
                    ref_sp = {n2, n1};
                end else begin
                    ref_regs[{op[5:4], 1'b0}] = n2;
                    ref_regs[{op[5:4], 1'b1}] = n1;
                end
            end
            8'h32: begin
                len = 2'd3;
                r   = '{pc: '0, cycles: 3'd4, wr_en: 1'b1, wr_addr: {n2, n1},
                        wr_data: ref_regs[7]};
            end
            8'h3a: begin
                len         = 2'd3;
                r.cycles    = 3'd4;
                ref_regs[7] = ref_mem[{n2, n1}];
            end
            default: begin
                if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin // LD r,n
                    len               = 2'd2;
                    r.cycles          = 3'd2;
                    ref_regs[op[5:3]] = n1;
                end
            end
        endcase
    end
    if (r.wr_en)
        ref_mem[r.wr_addr] = r.wr_data;
    r.pc   = ref_pc + {14'd0, len};
    ref_pc = r.pc;
    return r;
endfunction

`endif

// ==== tests/tb_z80_load_core.sv ====
`timescale 1ns/1ps

module tb_z80_load_core;

    `include "z80_ref_model.svh"

    logic        clk = 1'b0;
    logic        reset;
    logic [7:0]  mem_rdata;
    logic [15:0] o_addr;
    logic        o_read_mem;
    logic        o_write_mem;
    logic [7:0]  o_write_data;
    logic        o_done;

    logic [7:0]  tb_mem [0:65535];
    logic        load_mem = 1'b0;
    logic        mem_loaded = 1'b0;
    logic [15:0] lfsr_state;
    logic [15:0] prog_ptr;
    int          n_insn;

    z80_load_core dut0 (
        .clk          (clk),
        .reset        (reset),
        .i_mem_data   (mem_rdata),
        .o_addr       (o_addr),
        .o_read_mem   (o_read_mem),
        .o_write_mem  (o_write_mem),
        .o_write_data (o_write_data),
        .o_done       (o_done)
    );

    always #20 clk = ~clk;

    initial begin : reset_proc
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

    // combinational read, writes land on the edge
    assign mem_rdata = tb_mem[o_addr];

    always @(posedge clk or posedge load_mem) begin : mem_model
        logic [16:0] a;
        if (load_mem && !mem_loaded) begin
            for (a = 17'd0; a < 17'h10000; a++)
                tb_mem[a[15:0]] <= ref_mem[a[15:0]]; // image built by the generator
            mem_loaded <= 1'b1;
        end else if (o_write_mem) begin
            tb_mem[o_addr] <= o_write_data;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [7:0] take_bits(input int unsigned n);
        logic [7:0] v;
        v = 8'h00;
        for (int unsigned k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [2:0] pick_reg();
        logic [7:0] v;
        v = take_bits(3);
        return (v[2:0] == 3'd6) ? 3'd7 : v[2:0]; // slot 6 is (HL)
    endfunction

    // B, D and H stay at 0x80 so every pair points into the data area
    function automatic logic [2:0] pick_high_reg();
        logic [7:0] v;
        v = take_bits(2);
        case (v[1:0])
            2'd0:    return 3'd0;
            2'd1:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    function automatic logic is_high_reg(input logic [2:0] r);
        return (r == 3'd0) || (r == 3'd2) || (r == 3'd4);
    endfunction

    task automatic emit(input logic [7:0] b);
        ref_mem[prog_ptr] = b;
        prog_ptr = prog_ptr + 16'd1;
    endtask

    task automatic emit_random_insn();
        logic [7:0] grp;
        logic [7:0] v;
        logic [2:0] dst;
        logic [2:0] src;
        logic [1:0] pair;
        grp = take_bits(4) % 8'd10;
        case (grp)
            8'd0: begin
                v = take_bits(2);
                if (v[1:0] == 2'd1) begin
                    emit(8'h76);
                end else if (v[1:0] == 2'd2) begin
                    dst = pick_reg();
                    emit({2'b01, dst, 3'b110}); // LD r,(HL) is a nop here
                end else begin
                    emit(8'h00);
                end
            end
            8'd1: begin
                dst = pick_reg();
                src = is_high_reg(dst) ? pick_high_reg() : pick_reg();
                emit({2'b01, dst, src});
            end
            8'd2: begin
                dst = pick_reg();
                emit({2'b00, dst, 3'b110});
                emit(is_high_reg(dst) ? 8'h80 : take_bits(8));
            end
            8'd3: begin
                emit(8'h36);
                emit(take_bits(8));
            end
            8'd4: begin
                src = pick_reg();
                emit({5'b01110, src});
            end
            8'd5: begin
                v = take_bits(1);
                emit(v[0] ? 8'h12 : 8'h02);
            end
            8'd6: begin
                v = take_bits(1);
                emit(v[0] ? 8'h1a : 8'h0a);
            end
            8'd7: begin
                v = take_bits(2);
                pair = v[1:0] % 2'd3; // no SP
                emit({2'b00, pair, 4'b0001});
                emit(take_bits(8));
                emit(8'h80);
            end
            8'd8: begin
                emit(8'h3a);
                emit(take_bits(8));
                emit(8'h80);
            end
            default: begin
                emit(8'h32);
                emit(take_bits(8));
                emit(8'h80);
            end
        endcase
    endtask

    task automatic check_eq(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    endtask

    initial begin : compare_proc
        ref_step_t    exp;
        logic [16:0]  a;
        logic [7:0]   op;
        logic         write_pending;
        int unsigned  wait_cnt;
        int unsigned  cycles;

        lfsr_state = 16'd44868;
        prog_ptr   = 16'h0000;
        n_insn     = 0;
        for (a = 17'd0; a < 17'h10000; a++)
            ref_mem[a[15:0]] = 8'h00;
        for (a = 17'd0; a < 17'h100; a++)
            ref_mem[16'h8000 | a[15:0]] = take_bits(8);

        // pointers into the data area first
        emit(8'h21);
        emit(take_bits(8));
        emit(8'h80);
        emit(8'h01);
        emit(take_bits(8));
        emit(8'h80);
        emit(8'h11);
        emit(take_bits(8));
        emit(8'h80);
        n_insn = 3;
        repeat (200) begin
            emit_random_insn();
            n_insn++;
        end
        for (int r = 0; r < 6; r++) begin
            emit({5'b01110, r[2:0]}); // dump B..L through (HL)
            n_insn++;
        end
        emit(8'h32);
        emit(take_bits(8));
        emit(8'h80);
        n_insn++;

        load_mem <= 1'b1;
        ref_reset();

        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 30)
                timeout_fail("reset release");
        end while (reset);

        check_eq(16'(o_done), 16'd1, "o_done after reset");
        check_eq(16'(o_read_mem), 16'd1, "o_read_mem after reset");
        check_eq(16'(o_write_mem), 16'd0, "o_write_mem after reset");
        check_eq(o_addr, 16'h0000, "o_addr after reset");
        check_eq({8'h00, o_write_data}, 16'h0000, "o_write_data after reset");

        for (int i = 0; i < n_insn; i++) begin
            check_eq(o_addr, ref_pc, $sformatf("fetch address of insn %0d", i));
            check_eq(16'(o_read_mem), 16'd1, $sformatf("fetch strobe of insn %0d", i));
            op            = ref_mem[ref_pc];
            exp           = ref_step();
            write_pending = exp.wr_en;
            cycles        = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > 8)
                    timeout_fail($sformatf("o_done after opcode %h", op));
                check_eq(16'(o_read_mem & o_write_mem), 16'd0,
                         $sformatf("read and write together, opcode %h", op));
                if (o_write_mem) begin
                    check_eq(16'(write_pending), 16'd1,
                             $sformatf("unexpected write, opcode %h", op));
                    check_eq(o_addr, exp.wr_addr, $sformatf("write address, opcode %h", op));
                    check_eq({8'h00, o_write_data}, {8'h00, exp.wr_data},
                             $sformatf("write data, opcode %h", op));
                    write_pending = 1'b0;
                end
            end while (!o_done);
            check_eq(16'(cycles), 16'(exp.cycles), $sformatf("cycle count, opcode %h", op));
            check_eq(16'(write_pending), 16'd0, $sformatf("missing write, opcode %h", op));
        end
        check_eq(o_addr, ref_pc, "fetch address after the program");

        for (a = 17'd0; a < 17'h100; a++)
            check_eq({8'h00, tb_mem[16'h8000 | a[15:0]]}, {8'h00, ref_mem[16'h8000 | a[15:0]]},
                     $sformatf("data area byte %h", 16'h8000 | a[15:0]));

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
design/z80_seq_pkg.sv
design/register_file.sv
design/instr_decoder.sv
design/operand_collector.sv
design/load_sequencer.sv
design/z80_load_core.sv
tests/tb_z80_load_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_z80_load_core -f compile.f \
    -Mdir obj_dir -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit $build_status
fi

./obj_dir/sim_tb
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation failed with status $run_status"
    exit $run_status
fi
exit 0
